/* logic/gameGeomPkg.sv */
package gameGeomPkg;

	// Visible screen in pixels.
	localparam int SCREEN_W = 640;
	localparam int SCREEN_H = 480;

	// Positions and speeds are kept in 1/64 pixel units.
	localparam int FIXED_SCALE = 64;

	localparam int BALL_SIZE = 16;

	localparam int FLIPPER_W = 64;
	localparam int FLIPPER_H = 8;
	localparam int FLIPPER_Y = 440; // Fixed row.

	// Obstacle rectangle, top-left corner and size.
	localparam int OBST_X = 288;
	localparam int OBST_Y = 160;
	localparam int OBST_W = 64;
	localparam int OBST_H = 32;

endpackage

/* logic/objectPkg.sv */
package objectPkg;

	// Top-left pixel of a screen object.
	typedef struct packed {
		logic signed [10:0] x;
		logic signed [10:0] y;
	} objectPos;

	// Fixed-point units per frame.
	typedef struct packed {
		logic signed [15:0] x;
		logic signed [15:0] y;
	} ballVelocity;

	typedef struct packed {
		logic borderTop;
		logic borderLeft;
		logic borderRight;
		logic flipper;
		logic obstacle;
		logic [3:0] hitEdge; // Obstacle side struck as left, top, right, bottom from bit 3.
	} collisionFlags;

	typedef struct packed {
		ballVelocity startVel;
		logic pause;
	} levelSettings;

	// Register values after reset.
	localparam levelSettings LEVEL_DEFAULTS = '{
		startVel: '{x: 16'sd0, y: -16'sd128},
		pause: 1'b0
	};

endpackage

/* logic/frameTicker.sv */
`timescale 1ns/1ps

module frameTicker #(
	parameter int FRAME_CYCLES = 16
) (
	input logic clk,
	input logic resetN,
	output logic startOfFrame
);

	localparam int CNT_W = $clog2(FRAME_CYCLES);
	localparam logic [CNT_W-1:0] LAST = CNT_W'(FRAME_CYCLES - 1);

	logic [CNT_W-1:0] count;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			count <= '0;
			startOfFrame <= 1'b0;
		end else begin
			count <= (count == LAST) ? '0 : count + 1'b1;
			startOfFrame <= (count == LAST); // Stand-in for vertical sync.
		end
	end

	frameSingleCycle: assert property (@(posedge clk) disable iff (!resetN)
		startOfFrame |=> !startOfFrame);

endmodule

/* logic/levelConfig.sv */
`timescale 1ns/1ps

module levelConfig
	import objectPkg::*;
(
	input logic clk,
	input logic resetN,
	input logic cfgWrite,
	input logic [1:0] cfgAddr,
	input logic [15:0] cfgData,
	output levelSettings settings,
	output logic levelReset
);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			settings <= LEVEL_DEFAULTS;
		end else if (cfgWrite) begin
			case (cfgAddr)
				2'd0: settings.startVel.x <= signed'(cfgData);
				2'd1: settings.startVel.y <= signed'(cfgData);
				2'd2: settings.pause <= cfgData[0];
				default: ; // Address 3 only restarts.
			endcase
		end
	end

	// Restart pulse one cycle after the write.
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			levelReset <= 1'b0;
		else
			levelReset <= cfgWrite && (cfgAddr == 2'd3);
	end

endmodule

/* logic/flipperController.sv */
`timescale 1ns/1ps

module flipperController
	import gameGeomPkg::*, objectPkg::*;
#(
	parameter int FLIPPER_STEP = 4
) (
	input logic clk,
	input logic resetN,
	input logic keyLeft,
	input logic keyRight,
	input logic startOfFrame,
	input logic levelReset,
	output objectPos flipperPos,
	output logic signed [15:0] flipperSpeedX
);

	localparam logic signed [10:0] MAX_X = 11'(SCREEN_W - FLIPPER_W);
	localparam logic signed [10:0] CENTER_X = 11'((SCREEN_W - FLIPPER_W) / 2);
	localparam logic signed [10:0] STEP = 11'(FLIPPER_STEP);
	localparam logic signed [15:0] SPEED = 16'(FLIPPER_STEP * FIXED_SCALE);

	logic signed [10:0] posX;
	logic moveLeft;
	logic moveRight;

	assign moveLeft = keyLeft && !keyRight;
	assign moveRight = keyRight && !keyLeft;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			posX <= CENTER_X;
		end else if (levelReset) begin
			posX <= CENTER_X;
		end else if (startOfFrame) begin
			if (moveLeft)
				posX <= (posX < STEP) ? 11'sd0 : posX - STEP; // Stop at left edge.
			else if (moveRight)
				posX <= (posX > MAX_X - STEP) ? MAX_X : posX + STEP;
		end
	end

	assign flipperPos = '{x: posX, y: 11'(FLIPPER_Y)};

	// Fixed-point speed handed to the ball on a hit.
	assign flipperSpeedX = moveLeft ? -SPEED : (moveRight ? SPEED : 16'sd0);

	flipperOnScreen: assert property (@(posedge clk) disable iff (!resetN)
		(flipperPos.x >= 0) && (flipperPos.x <= MAX_X));

endmodule

/* logic/collisionDetector.sv */
`timescale 1ns/1ps

module collisionDetector
	import gameGeomPkg::*, objectPkg::*;
(
	input logic clk,
	input logic resetN,
	input objectPos ballPos,
	input objectPos flipperPos,
	input logic startOfFrame,
	input logic levelReset,
	output collisionFlags collisions,
	output logic obstacleAlive
);

	localparam logic signed [11:0] BS = 12'(BALL_SIZE);
	localparam logic signed [11:0] FW = 12'(FLIPPER_W);
	localparam logic signed [11:0] FH = 12'(FLIPPER_H);
	localparam logic signed [11:0] OX = 12'(OBST_X);
	localparam logic signed [11:0] OY = 12'(OBST_Y);
	localparam logic signed [11:0] OW = 12'(OBST_W);
	localparam logic signed [11:0] OH = 12'(OBST_H);
	localparam logic signed [11:0] RIGHT_X = 12'(SCREEN_W);

	logic signed [11:0] bx, by, fx, fy;
	logic signed [11:0] depthL, depthT, depthR, depthB;
	logic hitObst;
	logic [3:0] edgeSel;
	collisionFlags nextFlags;

	always_comb begin
		bx = 12'(ballPos.x);
		by = 12'(ballPos.y);
		fx = 12'(flipperPos.x);
		fy = 12'(flipperPos.y);

		// How far the ball reaches past each obstacle side.
		depthL = bx + BS - OX;
		depthR = OX + OW - bx;
		depthT = by + BS - OY;
		depthB = OY + OH - by;

		// One-cycle flag, then the obstacle is gone.
		hitObst = obstacleAlive && !collisions.obstacle &&
			(depthL > 0) && (depthR > 0) && (depthT > 0) && (depthB > 0);

		// Shallowest side is where the ball came in.
		if ((depthL <= depthR) && (depthL <= depthT) && (depthL <= depthB))
			edgeSel = 4'b1000;
		else if ((depthR <= depthT) && (depthR <= depthB))
			edgeSel = 4'b0010;
		else if (depthT <= depthB)
			edgeSel = 4'b0100;
		else
			edgeSel = 4'b0001;

		nextFlags.borderTop = (by <= 0);
		nextFlags.borderLeft = (bx <= 0);
		nextFlags.borderRight = (bx + BS >= RIGHT_X);
		nextFlags.flipper = (bx < fx + FW) && (bx + BS > fx) &&
			(by < fy + FH) && (by + BS > fy);
		nextFlags.obstacle = hitObst;
		nextFlags.hitEdge = hitObst ? edgeSel : 4'b0000;
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			collisions <= '0;
			obstacleAlive <= 1'b1;
		end else if (levelReset) begin
			collisions <= '0;
			obstacleAlive <= 1'b1;
		end else begin
			// Positions move on this edge, so the old flags are dropped.
			collisions <= startOfFrame ? '0 : nextFlags;
			if (collisions.obstacle)
				obstacleAlive <= 1'b0;
		end
	end

	edgeMatchesFlag: assert property (@(posedge clk) disable iff (!resetN)
		(collisions.hitEdge != 4'b0000) == collisions.obstacle);

endmodule

/* logic/ballController.sv */
`timescale 1ns/1ps

module ballController
	import gameGeomPkg::*, objectPkg::*;
#(
	parameter int INITIAL_X = 312,
	parameter int INITIAL_Y = 300
) (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,
	input logic levelReset,
	input collisionFlags collisions,
	input logic signed [15:0] flipperSpeedX,
	input levelSettings settings,
	output objectPos ballPos,
	output logic obstacleHit
);

	localparam logic signed [21:0] START_X = 22'(INITIAL_X * FIXED_SCALE);
	localparam logic signed [21:0] START_Y = 22'(INITIAL_Y * FIXED_SCALE);
	localparam logic signed [21:0] SCALE = 22'(FIXED_SCALE);

	logic signed [21:0] posFixX, posFixY;
	logic signed [21:0] pixX, pixY;
	logic signed [15:0] speedX, speedY;
	logic lockX, lockY; // One reversal per axis per frame.
	logic revY, revObstY, revX, revObstX, gainFlip;
	logic obstRevQ;
	logic hitInFrame;

	always_comb begin
		revY = (collisions.borderTop && speedY < 0) || (collisions.flipper && speedY > 0);
		revObstY = collisions.obstacle &&
			((collisions.hitEdge[0] && speedY < 0) || (collisions.hitEdge[2] && speedY > 0));
		revX = (collisions.borderLeft && speedX < 0) || (collisions.borderRight && speedX > 0);
		revObstX = collisions.obstacle &&
			((collisions.hitEdge[1] && speedX < 0) || (collisions.hitEdge[3] && speedX > 0));
		gainFlip = collisions.flipper && speedY > 0;
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			posFixY <= START_Y;
			speedY <= LEVEL_DEFAULTS.startVel.y;
			lockY <= 1'b0;
		end else if (levelReset) begin
			posFixY <= START_Y;
			speedY <= settings.startVel.y;
			lockY <= 1'b0;
		end else if (!settings.pause) begin
			if (!lockY && (revY || revObstY)) begin
				speedY <= -speedY;
				lockY <= 1'b1;
			end
			if (startOfFrame) begin
				posFixY <= posFixY + speedY;
				lockY <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			posFixX <= START_X;
			speedX <= LEVEL_DEFAULTS.startVel.x;
			lockX <= 1'b0;
		end else if (levelReset) begin
			posFixX <= START_X;
			speedX <= settings.startVel.x;
			lockX <= 1'b0;
		end else if (!settings.pause) begin
			if (!lockX) begin
				if (revX || revObstX) begin
					speedX <= -speedX;
					lockX <= 1'b1;
				end else if (gainFlip) begin
					speedX <= speedX + flipperSpeedX; // Flipper drags the ball.
					lockX <= 1'b1;
				end
			end
			if (startOfFrame) begin
				posFixX <= posFixX + speedX;
				lockX <= 1'b0;
			end
		end
	end

	// Obstacle reversals that actually took effect.
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			obstRevQ <= 1'b0;
			obstacleHit <= 1'b0;
			hitInFrame <= 1'b0;
		end else if (levelReset) begin
			obstRevQ <= 1'b0;
			obstacleHit <= 1'b0;
			hitInFrame <= 1'b0;
		end else begin
			obstRevQ <= !settings.pause &&
				((!lockY && !revY && revObstY) || (!lockX && !revX && revObstX));
			obstacleHit <= obstRevQ && !hitInFrame;
			if (obstRevQ)
				hitInFrame <= 1'b1;
			else if (startOfFrame)
				hitInFrame <= 1'b0;
		end
	end

	// Truncates toward zero.
	assign pixX = posFixX / SCALE;
	assign pixY = posFixY / SCALE;
	assign ballPos = '{x: pixX[10:0], y: pixY[10:0]};

	hitSingleCycle: assert property (@(posedge clk) disable iff (!resetN)
		obstacleHit |=> !obstacleHit);

endmodule

/* logic/breakoutCore.sv */
`timescale 1ns/1ps

module breakoutCore
	import objectPkg::*;
#(
	parameter int FRAME_CYCLES = 16,
	parameter int INITIAL_X = 312,
	parameter int INITIAL_Y = 300,
	parameter int FLIPPER_STEP = 4
) (
	input logic clk,
	input logic resetN,
	input logic keyLeft,
	input logic keyRight,
	input logic cfgWrite,
	input logic [1:0] cfgAddr,
	input logic [15:0] cfgData,
	output objectPos ballPos,
	output objectPos flipperPos,
	output logic obstacleHit,
	output logic obstacleAlive
);

	logic startOfFrame;
	logic levelReset;
	logic signed [15:0] flipperSpeedX;
	levelSettings settings;
	collisionFlags collisions;

	frameTicker #(.FRAME_CYCLES(FRAME_CYCLES)) frameTicker0 (
		.clk, .resetN, .startOfFrame
	);

	levelConfig levelConfig0 (
		.clk, .resetN, .cfgWrite, .cfgAddr, .cfgData, .settings, .levelReset
	);

	flipperController #(.FLIPPER_STEP(FLIPPER_STEP)) flipperController0 (
		.clk, .resetN, .keyLeft, .keyRight, .startOfFrame, .levelReset,
		.flipperPos, .flipperSpeedX
	);

	collisionDetector collisionDetector0 (
		.clk, .resetN, .ballPos, .flipperPos, .startOfFrame, .levelReset,
		.collisions, .obstacleAlive
	);

	ballController #(.INITIAL_X(INITIAL_X), .INITIAL_Y(INITIAL_Y)) ballController0 (
		.clk, .resetN, .startOfFrame, .levelReset, .collisions, .flipperSpeedX,
		.settings, .ballPos, .obstacleHit
	);

endmodule

/* sim/breakoutCoreTb.sv */
`timescale 1ns/1ps

module breakoutCoreTb
	import gameGeomPkg::*, objectPkg::*;
;

	localparam int FRAME_CYCLES = 16;
	localparam int STEP = 4;
	localparam int MAX_FLIP_X = SCREEN_W - FLIPPER_W;
	localparam int TIMEOUT_NS = 40 * 6 * FRAME_CYCLES * 100;

	logic clk, resetN, keyLeft, keyRight, cfgWrite;
	logic [1:0] cfgAddr;
	logic [15:0] cfgData;
	objectPos ballPos, flipperPos;
	logic obstacleHit, obstacleAlive;

	// Reference model state with the ball in 1/64 pixel units.
	int mx, my, mvx, mvy, mfx, mStartVx, mStartVy, cyc, holdFrames;
	logic mAlive, mPause, mHitPend, restartPend;
	logic [3:0] frameCount;
	logic frameTick;
	objectPos expBall, expFlipper;

	breakoutCore dut0 (
		.clk, .resetN, .keyLeft, .keyRight, .cfgWrite, .cfgAddr, .cfgData,
		.ballPos, .flipperPos, .obstacleHit, .obstacleAlive
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	task automatic failRun(string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic reportMismatch(string name, logic [31:0] got, logic [31:0] exp);
		failRun($sformatf("[ERROR] %s: DUT 0x%h, expected 0x%h", name, got, exp));
	endtask

	function automatic int dragSpeed();
		if (keyLeft && !keyRight)
			return -STEP * FIXED_SCALE;
		return (keyRight && !keyLeft) ? STEP * FIXED_SCALE : 0;
	endfunction

	// Bounce rules applied once per frame to the freshly moved ball.
	task automatic applyHits();
		int bx, by, dl, dr, dt, db;
		logic top, left, right, flip, obst, revY, revX, obstY, obstX, gain;
		logic [3:0] side;
		bx = mx / FIXED_SCALE;
		by = my / FIXED_SCALE;
		top = (by <= 0);
		left = (bx <= 0);
		right = (bx + BALL_SIZE >= SCREEN_W);
		flip = (bx < mfx + FLIPPER_W) && (bx + BALL_SIZE > mfx) &&
			(by < FLIPPER_Y + FLIPPER_H) && (by + BALL_SIZE > FLIPPER_Y);
		dl = bx + BALL_SIZE - OBST_X;
		dr = OBST_X + OBST_W - bx;
		dt = by + BALL_SIZE - OBST_Y;
		db = OBST_Y + OBST_H - by;
		obst = mAlive && (dl > 0) && (dr > 0) && (dt > 0) && (db > 0);
		if ((dl <= dr) && (dl <= dt) && (dl <= db))
			side = 4'b1000;
		else if ((dr <= dt) && (dr <= db))
			side = 4'b0010;
		else if (dt <= db)
			side = 4'b0100;
		else
			side = 4'b0001;
		revY = (top && mvy < 0) || (flip && mvy > 0);
		obstY = obst && ((side[0] && mvy < 0) || (side[2] && mvy > 0));
		revX = (left && mvx < 0) || (right && mvx > 0);
		obstX = obst && ((side[1] && mvx < 0) || (side[3] && mvx > 0));
		gain = flip && mvy > 0;
		if (!mPause) begin
			if (revX || obstX) begin
				mvx = -mvx;
				if (!revX)
					mHitPend = 1'b1;
			end else if (gain) begin
				mvx = mvx + dragSpeed();
			end
			if (revY || obstY) begin
				mvy = -mvy;
				if (!revY)
					mHitPend = 1'b1;
			end
		end
		if (obst)
			mAlive = 1'b0; // The detector keeps running during pause.
	endtask

	always @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			frameCount <= '0;
			frameTick <= 1'b0;
			mx = 312 * FIXED_SCALE;
			my = 300 * FIXED_SCALE;
			mvx = 0;
			mvy = -128;
			mfx = MAX_FLIP_X / 2;
			mStartVx = 0;
			mStartVy = -128;
			mAlive = 1'b1;
			mPause = 1'b0;
			mHitPend = 1'b0;
			restartPend = 1'b0;
			cyc = 7;
		end else begin
			frameCount <= (frameCount == FRAME_CYCLES - 1) ? '0 : frameCount + 1'b1;
			frameTick <= (frameCount == FRAME_CYCLES - 1);
			if (restartPend) begin
				mx = 312 * FIXED_SCALE;
				my = 300 * FIXED_SCALE;
				mvx = mStartVx;
				mvy = mStartVy;
				mfx = MAX_FLIP_X / 2;
				mAlive = 1'b1;
				mHitPend = 1'b0;
				cyc = 0;
			end else if (frameTick) begin
				if (keyLeft && !keyRight)
					mfx = (mfx < STEP) ? 0 : mfx - STEP;
				else if (keyRight && !keyLeft)
					mfx = (mfx > MAX_FLIP_X - STEP) ? MAX_FLIP_X : mfx + STEP;
				if (!mPause) begin
					mx = mx + mvx;
					my = my + mvy;
				end
				mHitPend = 1'b0;
				cyc = 0;
			end else begin
				if (cyc == 1)
					applyHits();
				cyc = (cyc < 7) ? cyc + 1 : 7;
			end
			restartPend = cfgWrite && (cfgAddr == 2'd3);
			if (cfgWrite && cfgAddr == 2'd0)
				mStartVx = int'($signed(cfgData));
			if (cfgWrite && cfgAddr == 2'd1)
				mStartVy = int'($signed(cfgData));
			if (cfgWrite && cfgAddr == 2'd2)
				mPause = cfgData[0];
		end
	end

	always_comb begin
		expBall = '{x: 11'(mx / FIXED_SCALE), y: 11'(my / FIXED_SCALE)};
		expFlipper = '{x: 11'(mfx), y: 11'(FLIPPER_Y)};
	end

	ballMatches: assert property (@(posedge clk) disable iff (!resetN) ballPos == expBall)
		else reportMismatch("ballPos", $sampled(ballPos), $sampled(expBall));
	flipperMatches: assert property (@(posedge clk) disable iff (!resetN)
		flipperPos == expFlipper)
		else reportMismatch("flipperPos", $sampled(flipperPos), $sampled(expFlipper));
	hitMatches: assert property (@(posedge clk) disable iff (!resetN)
		obstacleHit == (mHitPend && cyc == 3))
		else reportMismatch("obstacleHit", $sampled(obstacleHit), $sampled(mHitPend && cyc == 3));
	aliveMatches: assert property (@(posedge clk) disable iff (!resetN)
		obstacleAlive == mAlive)
		else reportMismatch("obstacleAlive", $sampled(obstacleAlive), $sampled(mAlive));
	ballBelowTop: assert property (@(posedge clk) disable iff (!resetN) ballPos.y >= 0)
		else failRun("The ball went above the top border.");

	// Returns 5 ns after the n-th frame strobe edge.
	task automatic waitFrames(int n);
		repeat (n) begin
			@(posedge clk);
			while (!frameTick)
				@(posedge clk);
		end
		#5;
	endtask

	task automatic writeReg(logic [1:0] addr, logic [15:0] data);
		cfgWrite = 1'b1;
		cfgAddr = addr;
		cfgData = data;
		@(posedge clk);
		#5 cfgWrite = 1'b0;
	endtask

	task automatic restartLevel(int vx, int vy);
		writeReg(2'd0, 16'(vx));
		writeReg(2'd1, 16'(vy));
		writeReg(2'd2, 16'd0);
		writeReg(2'd3, 16'd0);
	endtask

	initial begin
		#(TIMEOUT_NS * 1ns);
		failRun("Timeout: the tests did not finish in the expected number of frames.");
	end

	initial begin
		void'($urandom(58038));
		resetN = 1'b0;
		keyLeft = 1'b0;
		keyRight = 1'b0;
		cfgWrite = 1'b0;
		cfgAddr = 2'd0;
		cfgData = 16'd0;
		repeat (16) @(posedge clk);
		#5 resetN = 1'b1;
		waitFrames(2);

		// Straight fall while the flipper is nudged left for a while.
		restartLevel(0, 192);
		keyLeft = 1'b1;
		holdFrames = 8 + $urandom % 4;
		waitFrames(holdFrames);
		keyLeft = 1'b0;
		waitFrames(12 - holdFrames);

		// Top and left borders before the flipper runs into x 0 while paused.
		restartLevel(-640, -640);
		keyLeft = 1'b1;
		waitFrames(36);
		writeReg(2'd2, 16'd1);
		waitFrames(38);
		keyLeft = 1'b0;

		// Both keys first, then the right border and the flipper at the right edge.
		restartLevel(640, -640);
		keyLeft = 1'b1;
		keyRight = 1'b1;
		waitFrames(4);
		keyLeft = 1'b0;
		waitFrames(32);
		writeReg(2'd2, 16'd1);
		waitFrames(42);
		keyRight = 1'b0;

		// Ball lands on a flipper moving left.
		restartLevel(0, 640);
		waitFrames(9);
		keyLeft = 1'b1;
		waitFrames(11);
		keyLeft = 1'b0;

		// Obstacle hit and a pass through its old spot before pause and restart.
		restartLevel(0, -1280);
		waitFrames(34);
		writeReg(2'd2, 16'd1);
		waitFrames(3);
		restartLevel(0, -1280);
		waitFrames(2);

		$display("Done: no errors");
		$finish;
	end

endmodule

/* breakoutCore.f */
logic/gameGeomPkg.sv
logic/objectPkg.sv
logic/frameTicker.sv
logic/levelConfig.sv
logic/flipperController.sv
logic/collisionDetector.sv
logic/ballController.sv
logic/breakoutCore.sv
sim/breakoutCoreTb.sv
